/* Bender.yml */
package:
  name: cpucore

sources:
  - files:
      - hdl/cpuPkg.sv
      - hdl/fetchUnit.sv
      - hdl/decodeIssue.sv
      - hdl/regFile.sv
      - hdl/execStage.sv
      - hdl/lsuFifo.sv
      - hdl/fixedMemory.sv
      - hdl/cpuCore.sv
  - target: test
    files:
      - verif/cpuCoreTb.sv

/* flist.f */
hdl/cpuPkg.sv
hdl/fetchUnit.sv
hdl/decodeIssue.sv
hdl/regFile.sv
hdl/execStage.sv
hdl/lsuFifo.sv
hdl/fixedMemory.sv
hdl/cpuCore.sv
verif/cpuCoreTb.sv

/* hdl/cpuCore.sv */
module cpuCore (
    input  logic              clk,
    input  logic              rst,
    input  logic              run,
    input  cpuPkg::word_t     instr,
    output cpuPkg::word_t     instrAddr,
    output cpuPkg::regWrite_t aluWrite,
    output cpuPkg::regWrite_t memWrite
);

    logic                        stall;
    logic                        fetchValid;
    cpuPkg::word_t               fetchPc;
    cpuPkg::redirect_t           redirect;
    logic [cpuPkg::regCount-1:0] dirty;
    cpuPkg::regAddr_t            readAddrA;
    cpuPkg::regAddr_t            readAddrB;
    cpuPkg::word_t               readDataA;
    cpuPkg::word_t               readDataB;
    logic                        markValid;
    cpuPkg::regAddr_t            markAddr;
    cpuPkg::decoded_t            issue;
    logic                        issueValid;
    cpuPkg::lsuReq_t             lsuReq;
    logic                        lsuValid;
    logic                        lsuReady;
    cpuPkg::lsuReq_t             memReq;
    logic                        memReqValid;
    logic                        memReqReady;

    fetchUnit fetchUnit_inst (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .stall     (stall),
        .redirect  (redirect),
        .instrAddr (instrAddr),
        .fetchValid(fetchValid),
        .fetchPc   (fetchPc)
    );

    decodeIssue decodeIssue_inst (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .fetchValid(fetchValid),
        .fetchPc   (fetchPc),
        .redirect  (redirect),
        .dirty     (dirty),
        .readAddrA (readAddrA),
        .readAddrB (readAddrB),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .markValid (markValid),
        .markAddr  (markAddr),
        .issue     (issue),
        .issueValid(issueValid),
        .lsuReq    (lsuReq),
        .lsuValid  (lsuValid),
        .lsuReady  (lsuReady),
        .stall     (stall)
    );

    regFile regFile_inst (
        .clk      (clk),
        .rst      (rst),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .aluWrite (aluWrite),
        .memWrite (memWrite),
        .markValid(markValid),
        .markAddr (markAddr),
        .dirty    (dirty)
    );

    execStage execStage_inst (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .issueValid(issueValid),
        .aluWrite  (aluWrite),
        .redirect  (redirect)
    );

    lsuFifo lsuFifo_inst (
        .clk     (clk),
        .rst     (rst),
        .inData  (lsuReq),
        .inValid (lsuValid),
        .inReady (lsuReady),
        .outData (memReq),
        .outValid(memReqValid),
        .outReady(memReqReady)
    );

    fixedMemory fixedMemory_inst (
        .clk     (clk),
        .req     (memReq),
        .reqValid(memReqValid),
        .reqReady(memReqReady),
        .memWrite(memWrite)
    );

endmodule

/* hdl/cpuPkg.sv */
package cpuPkg;

    localparam int dataWidth = 16;
    localparam int regCount = 16;
    localparam int regAddrWidth = 4;
    localparam int memAddrWidth = 8;
    localparam int lsuFifoDepth = 4;
    localparam int lsuPtrWidth = $clog2(lsuFifoDepth);

    typedef logic [dataWidth-1:0] word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    // Major opcode in instruction bits 15..12, codes 14 and 15 act as NOP
    typedef enum logic [3:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        AND  = 4'd3,
        OR   = 4'd4,
        XOR  = 4'd5,
        SHL  = 4'd6,
        SHR  = 4'd7,
        LI   = 4'd8,
        LUI  = 4'd9,
        LD   = 4'd10,
        ST   = 4'd11,
        BEQZ = 4'd12,
        JAL  = 4'd13
    } opcode_t;

    // Operand B already carries the immediate where the opcode has one
    typedef struct packed {
        opcode_t  op;
        regAddr_t rd;
        logic     writeEn;
        word_t    a;
        word_t    b;
        logic     isBranch;
        logic     isJal;
        word_t    pc;
    } decoded_t;

    typedef struct packed {
        logic                    isStore;
        logic [memAddrWidth-1:0] addr;
        word_t                   storeData;
        regAddr_t                rd;
    } lsuReq_t;

    typedef struct packed {
        logic     valid;
        regAddr_t addr;
        word_t    data;
    } regWrite_t;

    typedef struct packed {
        logic  resolved;
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

/* hdl/decodeIssue.sv */
module decodeIssue (
    input  logic                         clk,
    input  logic                         rst,
    input  cpuPkg::word_t                instr,
    input  logic                         fetchValid,
    input  cpuPkg::word_t                fetchPc,
    input  cpuPkg::redirect_t            redirect,
    input  logic [cpuPkg::regCount-1:0]  dirty,
    output cpuPkg::regAddr_t             readAddrA,
    output cpuPkg::regAddr_t             readAddrB,
    input  cpuPkg::word_t                readDataA,
    input  cpuPkg::word_t                readDataB,
    output logic                         markValid,
    output cpuPkg::regAddr_t             markAddr,
    output cpuPkg::decoded_t             issue,
    output logic                         issueValid,
    output cpuPkg::lsuReq_t              lsuReq,
    output logic                         lsuValid,
    input  logic                         lsuReady,
    output logic                         stall
);

    logic             holdValid;
    cpuPkg::word_t    holdInstr;
    cpuPkg::word_t    holdPc;
    logic             branchPending;
    logic             curValid;
    cpuPkg::word_t    curInstr;
    cpuPkg::word_t    curPc;
    cpuPkg::opcode_t  op;
    cpuPkg::regAddr_t rd;
    logic             useA;
    logic             useB;
    logic             writesRd;
    logic             writeEn;
    logic             isMem;
    logic             isControl;
    logic             hazard;
    logic             go;
    logic             fire;
    logic             blocked;

    // Held word takes priority over the fetch slot
    assign curValid = holdValid || fetchValid;
    assign curInstr = holdValid ? holdInstr : instr;
    assign curPc = holdValid ? holdPc : fetchPc;

    assign op = cpuPkg::opcode_t'(curInstr[15:12]);
    assign rd = curInstr[11:8];

    always_comb begin
        useA = 1'b0;
        useB = 1'b0;
        writesRd = 1'b0;
        case (op)
            cpuPkg::ADD, cpuPkg::SUB, cpuPkg::AND, cpuPkg::OR, cpuPkg::XOR,
            cpuPkg::SHL, cpuPkg::SHR: begin
                useA = 1'b1;
                useB = 1'b1;
                writesRd = 1'b1;
            end
            cpuPkg::LI: begin
                writesRd = 1'b1;
            end
            cpuPkg::LUI, cpuPkg::LD, cpuPkg::JAL: begin
                useA = 1'b1;
                writesRd = 1'b1;
            end
            cpuPkg::ST, cpuPkg::BEQZ: begin
                useA = 1'b1;
                useB = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // LUI reads its own destination to keep the low byte
    assign readAddrA = (op == cpuPkg::LUI) ? rd : curInstr[7:4];
    assign readAddrB = curInstr[3:0];

    assign writeEn = writesRd && (rd != '0);
    assign isMem = (op == cpuPkg::LD) || (op == cpuPkg::ST);
    assign isControl = (op == cpuPkg::BEQZ) || (op == cpuPkg::JAL);

    assign hazard = (useA && dirty[readAddrA]) || (useB && dirty[readAddrB])
                  || (writeEn && dirty[rd]);
    assign go = !hazard && !branchPending && (!isMem || lsuReady);
    assign fire = curValid && go;
    assign blocked = curValid && !go;

    // Fetch also waits from a control issue until execute resolves it
    assign stall = blocked || (fire && isControl) || (branchPending && !redirect.resolved);

    assign issueValid = fire && !isMem;
    assign markValid = fire && writeEn;
    assign markAddr = rd;

    // FIFO valid never looks at ready
    assign lsuValid = curValid && isMem && !hazard && !branchPending;
    assign lsuReq.isStore = (op == cpuPkg::ST);
    assign lsuReq.addr = readDataA[cpuPkg::memAddrWidth-1:0];
    assign lsuReq.storeData = readDataB;
    assign lsuReq.rd = rd;

    always_comb begin
        issue.op = op;
        issue.rd = rd;
        issue.writeEn = writeEn;
        issue.a = readDataA;
        case (op)
            cpuPkg::LI: issue.b = {{8{curInstr[7]}}, curInstr[7:0]};
            cpuPkg::LUI: issue.b = {curInstr[7:0], 8'h00};
            default: issue.b = readDataB;
        endcase
        issue.isBranch = (op == cpuPkg::BEQZ);
        issue.isJal = (op == cpuPkg::JAL);
        issue.pc = curPc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            holdValid <= 1'b0;
            branchPending <= 1'b0;
        end else begin
            holdValid <= blocked;
            if (fire && isControl) begin
                branchPending <= 1'b1;
            end else if (redirect.resolved) begin
                branchPending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (blocked) begin
            holdInstr <= curInstr;
            holdPc <= curPc;
        end
    end

endmodule

/* hdl/execStage.sv */
module execStage (
    input  logic               clk,
    input  logic               rst,
    input  cpuPkg::decoded_t   issue,
    input  logic               issueValid,
    output cpuPkg::regWrite_t  aluWrite,
    output cpuPkg::redirect_t  redirect
);

    cpuPkg::decoded_t cur;
    logic             curValid;
    cpuPkg::word_t    linkValue;
    cpuPkg::word_t    result;
    logic             isControl;

    always_ff @(posedge clk) begin
        if (rst) begin
            curValid <= 1'b0;
        end else begin
            curValid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid) begin
            cur <= issue;
        end
    end

    assign linkValue = cur.pc + cpuPkg::word_t'(1);

    always_comb begin
        case (cur.op)
            cpuPkg::ADD: result = cur.a + cur.b;
            cpuPkg::SUB: result = cur.a - cur.b;
            cpuPkg::AND: result = cur.a & cur.b;
            cpuPkg::OR: result = cur.a | cur.b;
            cpuPkg::XOR: result = cur.a ^ cur.b;
            cpuPkg::SHL: result = cur.a << cur.b[3:0];
            cpuPkg::SHR: result = cur.a >> cur.b[3:0];
            cpuPkg::LI: result = cur.b;
            // Upper byte from the immediate, low byte kept from rd
            cpuPkg::LUI: result = {cur.b[15:8], cur.a[7:0]};
            cpuPkg::JAL: result = linkValue;
            default: result = '0;
        endcase
    end

    assign aluWrite.valid = curValid && cur.writeEn;
    assign aluWrite.addr = cur.rd;
    assign aluWrite.data = result;

    assign isControl = cur.isBranch || cur.isJal;

    // BEQZ jumps to rb when ra is zero, JAL always jumps to ra
    assign redirect.resolved = curValid && isControl;
    assign redirect.taken = cur.isJal || (cur.isBranch && (cur.a == '0));
    assign redirect.target = cur.isJal ? cur.a : cur.b;

endmodule

/* hdl/fetchUnit.sv */
module fetchUnit (
    input  logic              clk,
    input  logic              rst,
    input  logic              run,
    input  logic              stall,
    input  cpuPkg::redirect_t redirect,
    output cpuPkg::word_t     instrAddr,
    output logic              fetchValid,
    output cpuPkg::word_t     fetchPc
);

    logic request;
    logic redirectTaken;
    logic reqValid;

    assign redirectTaken = redirect.resolved && redirect.taken;

    // A taken redirect wins, the old address is never requested
    assign request = run && !stall && !redirectTaken;

    always_ff @(posedge clk) begin
        if (rst) begin
            instrAddr <= '0;
            reqValid <= 1'b0;
        end else begin
            reqValid <= request;
            if (redirectTaken) begin
                instrAddr <= redirect.target;
            end else if (request) begin
                instrAddr <= instrAddr + cpuPkg::word_t'(1);
            end
        end
    end

    // Address of the word that shows up on instr next cycle
    always_ff @(posedge clk) begin
        fetchPc <= instrAddr;
    end

    // Cycles without a request deliver nothing
    assign fetchValid = reqValid;

endmodule

/* hdl/fixedMemory.sv */
module fixedMemory (
    input  logic              clk,
    input  cpuPkg::lsuReq_t   req,
    input  logic              reqValid,
    output logic              reqReady,
    output cpuPkg::regWrite_t memWrite
);

    cpuPkg::word_t mem [2**cpuPkg::memAddrWidth];
    logic          isLoad;

    // One access per cycle, never busy
    assign reqReady = 1'b1;

    assign isLoad = reqValid && !req.isStore;

    always_ff @(posedge clk) begin
        if (reqValid && req.isStore) begin
            mem[req.addr] <= req.storeData;
        end
    end

    // Load result one cycle after acceptance
    always_ff @(posedge clk) begin
        memWrite.valid <= isLoad && (req.rd != '0);
    end

    always_ff @(posedge clk) begin
        if (isLoad) begin
            memWrite.addr <= req.rd;
            memWrite.data <= mem[req.addr];
        end
    end

endmodule

/* hdl/lsuFifo.sv */
module lsuFifo (
    input  logic            clk,
    input  logic            rst,
    input  cpuPkg::lsuReq_t inData,
    input  logic            inValid,
    output logic            inReady,
    output cpuPkg::lsuReq_t outData,
    output logic            outValid,
    input  logic            outReady
);

    cpuPkg::lsuReq_t buffer [cpuPkg::lsuFifoDepth];
    logic [cpuPkg::lsuPtrWidth-1:0] wrPtr;
    logic [cpuPkg::lsuPtrWidth-1:0] rdPtr;
    logic [cpuPkg::lsuPtrWidth:0] count;
    logic push;
    logic pop;

    assign inReady = (count != cpuPkg::lsuFifoDepth);
    assign outValid = (count != '0);
    assign outData = buffer[rdPtr];

    assign push = inValid && inReady;
    assign pop = outValid && outReady;

    always_ff @(posedge clk) begin
        if (push) begin
            buffer[wrPtr] <= inData;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + push - pop;
        end
    end

endmodule

/* hdl/regFile.sv */
module regFile (
    input  logic                        clk,
    input  logic                        rst,
    input  cpuPkg::regAddr_t            readAddrA,
    input  cpuPkg::regAddr_t            readAddrB,
    output cpuPkg::word_t               readDataA,
    output cpuPkg::word_t               readDataB,
    input  cpuPkg::regWrite_t           aluWrite,
    input  cpuPkg::regWrite_t           memWrite,
    input  logic                        markValid,
    input  cpuPkg::regAddr_t            markAddr,
    output logic [cpuPkg::regCount-1:0] dirty
);

    cpuPkg::word_t regs [cpuPkg::regCount];
    logic [cpuPkg::regCount-1:0] dirtyNext;

    // Register 0 is never stored, reads as zero
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

    always_ff @(posedge clk) begin
        if (aluWrite.valid && (aluWrite.addr != '0)) begin
            regs[aluWrite.addr] <= aluWrite.data;
        end
        if (memWrite.valid && (memWrite.addr != '0)) begin
            regs[memWrite.addr] <= memWrite.data;
        end
    end

    // Retiring writes clear, a new issue sets
    always_comb begin
        dirtyNext = dirty;
        if (aluWrite.valid) begin
            dirtyNext[aluWrite.addr] = 1'b0;
        end
        if (memWrite.valid) begin
            dirtyNext[memWrite.addr] = 1'b0;
        end
        if (markValid) begin
            dirtyNext[markAddr] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dirty <= '0;
        end else begin
            dirty <= dirtyNext;
        end
    end

endmodule

/* verif/cpuCoreTb.sv */
module cpuCoreTb;

    localparam int maxTests = 8;
    localparam int progDepth = 32;
    localparam int maxWrites = 16;
    localparam int imemDepth = 256;

    logic              clk;
    logic              rst;
    logic              run;
    cpuPkg::word_t     instr;
    cpuPkg::word_t     instrAddr;
    cpuPkg::regWrite_t aluWrite;
    cpuPkg::regWrite_t memWrite;

    string             testName [maxTests];
    int                progLen [maxTests];
    int                aluCount [maxTests];
    int                memCount [maxTests];
    int                pauseAt [maxTests];
    cpuPkg::word_t     progWords [maxTests][progDepth];
    cpuPkg::regWrite_t aluExp [maxTests][maxWrites];
    cpuPkg::regWrite_t memExp [maxTests][maxWrites];
    cpuPkg::word_t     imem [imemDepth];

    int    testCount;
    int    passCount;
    int    failCount;
    int    testErrors;
    int    cycleLimit;
    string curName;

    cpuCore cpuCore_inst (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .instr    (instr),
        .instrAddr(instrAddr),
        .aluWrite (aluWrite),
        .memWrite (memWrite)
    );

    initial clk = 1'b0;

    always begin
        #20 clk = ~clk;
    end

    // Instruction memory answers one cycle after the address
    always @(posedge clk) begin
        instr <= imem[instrAddr[7:0]];
    end

    task automatic readPatterns();
        int               fd;
        int               code;
        int               t;
        string            token;
        logic [8*128-1:0] skipped;
        cpuPkg::regAddr_t regNum;
        cpuPkg::word_t    value;
        testCount = 0;
        fd = $fopen("verif/cpuPatterns.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/cpuPatterns.txt");
        end else begin
            while ($fscanf(fd, "%s", token) == 1) begin
                if (token == "#") begin
                    code = $fgets(skipped, fd);
                end else if (token == "test" && testCount < maxTests) begin
                    t = testCount;
                    code = $fscanf(fd, "%s %d %d %d %d", testName[t], progLen[t],
                                   aluCount[t], memCount[t], pauseAt[t]);
                    for (int i = 0; i < progLen[t]; i++) begin
                        code = $fscanf(fd, "%h", progWords[t][i]);
                    end
                    for (int i = 0; i < aluCount[t]; i++) begin
                        code = $fscanf(fd, "%h %h", regNum, value);
                        aluExp[t][i].valid = 1'b1;
                        aluExp[t][i].addr = regNum;
                        aluExp[t][i].data = value;
                    end
                    for (int i = 0; i < memCount[t]; i++) begin
                        code = $fscanf(fd, "%h %h", regNum, value);
                        memExp[t][i].valid = 1'b1;
                        memExp[t][i].addr = regNum;
                        memExp[t][i].data = value;
                    end
                    testCount++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic checkAluWrite(input cpuPkg::regWrite_t expected,
                                 input cpuPkg::regWrite_t actual);
        if (actual.addr !== expected.addr || actual.data !== expected.data) begin
            $display("ERROR %s aluWrite expected r%0d=%h actual r%0d=%h", curName,
                     expected.addr, expected.data, actual.addr, actual.data);
            testErrors++;
        end
    endtask

    task automatic checkMemWrite(input cpuPkg::regWrite_t expected,
                                 input cpuPkg::regWrite_t actual);
        if (actual.addr !== expected.addr || actual.data !== expected.data) begin
            $display("ERROR %s memWrite expected r%0d=%h actual r%0d=%h", curName,
                     expected.addr, expected.data, actual.addr, actual.data);
            testErrors++;
        end
    endtask

    task automatic checkIdle();
        if (instrAddr !== '0 || aluWrite.valid !== 1'b0 || memWrite.valid !== 1'b0) begin
            $display("ERROR %s reset expected instrAddr=0000 valids=0/0 actual %h %b/%b",
                     curName, instrAddr, aluWrite.valid, memWrite.valid);
            testErrors++;
        end
    endtask

    task automatic resetCore();
        @(posedge clk);
        rst <= 1'b1;
        run <= 1'b0;
        for (int i = 1; i <= 4; i++) begin
            @(posedge clk);
            if (i == 4) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            // Outputs are defined from the second reset cycle on
            if (i >= 2) begin
                checkIdle();
            end
        end
    endtask

    task automatic runTest(input int t);
        int cycle;
        int idle;
        int settle;
        int aluIdx;
        int memIdx;
        bit sawWrite;
        bit done;
        curName = testName[t];
        testErrors = 0;
        for (int a = 0; a < imemDepth; a++) begin
            imem[a] = {8'hE0, a[7:0]};
        end
        for (int i = 0; i < progLen[t]; i++) begin
            imem[i] = progWords[t][i];
        end
        resetCore();
        @(posedge clk);
        run <= 1'b1;
        cycle = 0;
        idle = 0;
        settle = 0;
        aluIdx = 0;
        memIdx = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            cycle++;
            if (pauseAt[t] > 0 && cycle == pauseAt[t]) begin
                run <= 1'b0;
            end else if (pauseAt[t] > 0 && cycle == pauseAt[t] + 4) begin
                run <= 1'b1;
            end
            @(negedge clk);
            sawWrite = 1'b0;
            if (aluWrite.valid === 1'b1) begin
                sawWrite = 1'b1;
                if (aluIdx < aluCount[t]) begin
                    checkAluWrite(aluExp[t][aluIdx], aluWrite);
                    aluIdx++;
                end else begin
                    $display("%s: unexpected aluWrite r%0d=%h", curName,
                             aluWrite.addr, aluWrite.data);
                    testErrors++;
                end
            end
            if (memWrite.valid === 1'b1) begin
                sawWrite = 1'b1;
                if (memIdx < memCount[t]) begin
                    checkMemWrite(memExp[t][memIdx], memWrite);
                    memIdx++;
                end else begin
                    $display("%s: unexpected memWrite r%0d=%h", curName,
                             memWrite.addr, memWrite.data);
                    testErrors++;
                end
            end
            idle = sawWrite ? 0 : idle + 1;
            // Keep watching a little for stray writes
            if (aluIdx == aluCount[t] && memIdx == memCount[t]) begin
                settle++;
                done = (settle >= 10);
            end else if (idle >= 20) begin
                $display("%s: write missing, got %0d of %0d aluWrite and %0d of %0d memWrite",
                         curName, aluIdx, aluCount[t], memIdx, memCount[t]);
                testErrors++;
                done = 1'b1;
            end
        end
        if (testErrors == 0) begin
            passCount++;
            $display("PASS %s", curName);
        end else begin
            failCount++;
            $display("FAIL %s with %0d errors", curName, testErrors);
        end
    endtask

    initial begin
        rst = 1'b1;
        run = 1'b0;
        instr = '0;
        passCount = 0;
        failCount = 0;
        cycleLimit = 0;
        curName = "setup";
        readPatterns();
        for (int t = 0; t < testCount; t++) begin
            cycleLimit += progLen[t] * 10 + 40;
        end
        if (testCount == 0) begin
            $display("no tests were read from the patterns file");
            failCount = 1;
        end else begin
            for (int t = 0; t < testCount; t++) begin
                runTest(t);
            end
        end
        $display("pass count %0d, fail count %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog sized from the program lengths
    initial begin
        wait (cycleLimit > 0);
        repeat (cycleLimit) @(posedge clk);
        $display("timeout after %0d cycles, the run did not finish", cycleLimit);
        $display("tests failed");
        $finish;
    end

endmodule

/* verif/cpuPatterns.txt */
# test <name> <words> <alu writes> <mem writes> <pause cycle, 0 for none>, then program words
# from address 0, then expected aluWrite and memWrite as <reg> <data> hex pairs in that order
test resetStart 3 2 0 0  8105 8F02 C00F
    1 0005  F 0002
test aluOps 15 13 0 0
    810C 8205 91A0 1312 2421 3513 4612 5713 6822 89F8 7A92 6B29 1012 8F0E C00F
    1 000C  2 0005  1 A00C  3 A011  4 5FF9  5 A000  6 A00D  7 001D  8 00A0  9 FFF8
    A 07FF  B 0500  F 000E
test hazardChain 8 7 0 0  8103 1211 1321 2332 6431 5142 8F07 C00F
    1 0003  2 0006  3 0009  3 0003  4 0018  1 001E  F 0007
test memoryOps 15 7 4 0
    8110 8211 8312 845A 8581 B014 B025 B031 A610 A720 A830 A980 1A97 8F0E C00F
    1 0010  2 0011  3 0012  4 005A  5 FF81  A FFDB  F 000E
    6 005A  7 FF81  8 0010  9 005A
test controlFlow 13 6 0 0  8105 8205 C002 8333 8444 C012 850A D650 8777 8888 8909 8F0C C00F
    1 0005  2 0005  5 000A  6 0008  9 0009  F 000C
test pauseRun 10 7 1 6  8120 827F B012 1322 A410 2534 86C3 4765 8F09 C00F
    1 0020  2 007F  3 00FE  5 007F  6 FFC3  7 FFFF  F 0009
    4 007F
